// ==== common/xcorr_consts.svh ====
////////////////////////////////////////
// correlator bank constants
// sample and result widths, window length,
// lane count, FIFO depth and tag codes
////////////////////////////////////////

`ifndef XCORR_CONSTS_SVH
`define XCORR_CONSTS_SVH

// signed input sample
`define SAMPLE_W 8

// correlation window, in samples
`define TAG_LEN 8

`define NUM_TAGS 4
`define FIFO_DEPTH 16

// sample width plus log2 of the window
`define CORR_W 11

// one byte per lane, lane 0 in the low byte
// bit 0 of each code pairs with the newest sample
`define TAG_CODES 32'h3CE15AB4

`endif

// ==== common/xcorr_pkg.sv ====
////////////////////////////////////////
// correlator bank package
// shared sample, result and code types,
// lane state and the tag code lookup
////////////////////////////////////////

`include "xcorr_consts.svh"

package xcorr_pkg;

  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  typedef logic signed [`CORR_W-1:0] corr_t;

  // 1 means +1, 0 means -1
  typedef logic [`TAG_LEN-1:0] tag_code_t;

  // fill until the window holds TAG_LEN samples
  typedef enum logic {
    LANE_FILL,
    LANE_RUN
  } lane_state_t;

  ////////////////////////////////////////
  // tag code of one lane
  ////////////////////////////////////////

  function automatic tag_code_t tag_code(input int lane);
    logic [`NUM_TAGS*`TAG_LEN-1:0] codes;
    codes = `TAG_CODES;
    return codes[lane*`TAG_LEN +: `TAG_LEN];
  endfunction

endpackage

// ==== project.f ====
+incdir+common
common/xcorr_pkg.sv
src/sample_fifo.sv
xcorr_lane/xcorr_lane.sv
src/xcorr_all.sv
tests/xcorr_all_sva.sv
tests/xcorr_all_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the correlator bank testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module xcorr_all_tb \
  -o xcorr_all_sim \
  && ./obj_dir/xcorr_all_sim | tee sim.log \
  && grep -qx "sim passed" sim.log \
  || { echo "simulation failed"; exit 1; }
echo "simulation ok"

// ==== src/sample_fifo.sv ====
////////////////////////////////////////
// sample FIFO
// synchronous first-word-fall-through queue
// that pops when every lane is ready
////////////////////////////////////////

`timescale 1ns/1ps

`include "xcorr_consts.svh"

module sample_fifo (
  input  logic                  clk,
  input  logic                  rst_n,

  // write side
  input  logic                  in_valid,
  output logic                  in_ready,
  input  xcorr_pkg::sample_t    in_data,

  // lane side
  input  logic [`NUM_TAGS-1:0]  lane_ready,
  output logic                  sample_take,
  output xcorr_pkg::sample_t    sample_data
);

  import xcorr_pkg::*;

  localparam int addr_w = $clog2(`FIFO_DEPTH);
  localparam int cnt_w = $clog2(`FIFO_DEPTH + 1);

  localparam logic [addr_w-1:0] last_addr = addr_w'(`FIFO_DEPTH - 1);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(`FIFO_DEPTH);

  sample_t mem [`FIFO_DEPTH];

  logic [addr_w-1:0] wr_ptr;
  logic [addr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  logic wr_en;
  logic empty;

  function automatic logic [addr_w-1:0] ptr_inc(input logic [addr_w-1:0] ptr);
    if (ptr == last_addr) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign in_ready = (count != full_cnt);
  assign wr_en = in_valid && in_ready;

  // one pop strobe shared by all lanes
  assign sample_take = !empty && (&lane_ready);

  // head entry is always on the output
  assign sample_data = mem[rd_ptr];

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (sample_take) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, sample_take})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/xcorr_all.sv ====
////////////////////////////////////////
// tag correlator bank
// one input FIFO broadcast to NUM_TAGS
// lanes, lanes removable by disable_mask
////////////////////////////////////////

`timescale 1ns/1ps

`include "xcorr_consts.svh"

module xcorr_all #(
  parameter logic [`NUM_TAGS-1:0] disable_mask = '0
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // sample input
  input  logic                                  in_valid,
  output logic                                  in_ready,
  input  xcorr_pkg::sample_t                    in_data,

  // per-lane result streams
  output logic [`NUM_TAGS-1:0]                  corr_valid,
  input  logic [`NUM_TAGS-1:0]                  corr_ready,
  output xcorr_pkg::corr_t [`NUM_TAGS-1:0]      corr_data
);

  import xcorr_pkg::*;

  logic sample_take;
  sample_t sample_data;
  logic [`NUM_TAGS-1:0] lane_ready;

  sample_fifo fifo_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_data     (in_data),
    .lane_ready  (lane_ready),
    .sample_take (sample_take),
    .sample_data (sample_data)
  );

  ////////////////////////////////////////
  // lanes
  ////////////////////////////////////////

  for (genvar k = 0; k < `NUM_TAGS; k++) begin : g_lane
    if (!disable_mask[k]) begin : g_on
      xcorr_lane #(
        .lane_id (k)
      ) lane_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_take (sample_take),
        .sample_data (sample_data),
        .lane_ready  (lane_ready[k]),
        .corr_valid  (corr_valid[k]),
        .corr_ready  (corr_ready[k]),
        .corr_data   (corr_data[k])
      );
    end else begin : g_off
      // removed lane never holds back the FIFO
      assign lane_ready[k] = 1'b1;
      assign corr_valid[k] = 1'b0;
      assign corr_data[k] = '0;
    end
  end

endmodule

// ==== tests/xcorr_all_sva.sv ====
////////////////////////////////////////
// correlator bank assertions
// FIFO and lane handshake rules
////////////////////////////////////////

`timescale 1ns/1ps

`include "xcorr_consts.svh"

module xcorr_all_sva #(
  parameter logic [`NUM_TAGS-1:0] disable_mask = '0
) (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                in_ready,
  input logic [$clog2(`FIFO_DEPTH)-1:0]      wr_ptr,
  input logic [`NUM_TAGS-1:0]                corr_valid,
  input logic [`NUM_TAGS-1:0]                corr_ready,
  input xcorr_pkg::corr_t [`NUM_TAGS-1:0]    corr_data
);

  // stalled result must not move
  for (genvar k = 0; k < `NUM_TAGS; k++) begin : g_hold
    a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
      corr_valid[k] && !corr_ready[k] |=> $stable(corr_data[k]))
      else $error("lane %0d changed corr_data while stalled", k);
  end

  // full FIFO takes no write
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    !in_ready |=> $stable(wr_ptr))
    else $error("FIFO write pointer moved while in_ready was low");

  a_off_lane_idle: assert property (@(posedge clk)
    (corr_valid & disable_mask) == '0)
    else $error("a disabled lane raised corr_valid");

  a_reset_idle: assert property (@(posedge clk)
    !rst_n |=> corr_valid == '0)
    else $error("corr_valid high in the cycle after reset");

endmodule

bind xcorr_all xcorr_all_sva #(
  .disable_mask (disable_mask)
) sva_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_ready   (in_ready),
  .wr_ptr     (fifo_i.wr_ptr),
  .corr_valid (corr_valid),
  .corr_ready (corr_ready),
  .corr_data  (corr_data)
);

// ==== tests/xcorr_all_tb.sv ====
////////////////////////////////////////
// correlator bank testbench
// table-driven sample streams checked
// against a sliding-window model
////////////////////////////////////////

`timescale 1ns/1ps

`include "xcorr_consts.svh"

module xcorr_all_tb;

  import xcorr_pkg::*;

  // lane 2 is removed at build time
  localparam logic [`NUM_TAGS-1:0] lane_off = 4'b0100;

  localparam int ready_all = 0;
  localparam int ready_rand = 1;
  localparam int ready_hold0 = 2;
  localparam int num_tests = 5;

  logic clk;
  logic rst_n;
  logic in_valid;
  logic in_ready;
  sample_t in_data;
  logic [`NUM_TAGS-1:0] corr_valid;
  logic [`NUM_TAGS-1:0] corr_ready;
  corr_t [`NUM_TAGS-1:0] corr_data;

  ////////////////////////////////////////
  // test table
  ////////////////////////////////////////

  string test_name [num_tests] = '{"steady", "sparse", "rand_ready", "hold_lane0", "mixed"};
  int test_len [num_tests] = '{40, 30, 60, 50, 40};
  int valid_pct [num_tests] = '{100, 40, 80, 100, 60};
  int ready_mode [num_tests] = '{ready_all, ready_all, ready_rand, ready_hold0, ready_rand};
  int hold_len [num_tests] = '{0, 0, 0, 60, 0};

  // lane 0 first
  // bit 0 pairs with the newest sample
  logic [`TAG_LEN-1:0] lane_code [`NUM_TAGS] = '{8'hB4, 8'h5A, 8'hE1, 8'h3C};

  logic [31:0] rng = 32'h908f8af9;
  int win_q [$];
  int exp_q [`NUM_TAGS][$];
  logic in_fire;
  logic saw_full;
  int check_cnt;
  int err_cnt;
  int cycle_cnt = 0;
  int cycle_limit = 1000000;

  xcorr_all #(
    .disable_mask (lane_off)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .corr_valid (corr_valid),
    .corr_ready (corr_ready),
    .corr_data  (corr_data)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // newest sample sits at index 0 of the window
  function automatic int window_corr(input int lane);
    int acc;
    acc = 0;
    for (int i = 0; i < `TAG_LEN; i++) begin
      acc = lane_code[lane][i] ? acc + win_q[i] : acc - win_q[i];
    end
    return acc;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int k = 0; k < `NUM_TAGS; k++) begin
      n = n + exp_q[k].size();
    end
    return n;
  endfunction

  function automatic logic [`NUM_TAGS-1:0] ready_pattern(input int row, input int t);
    logic [31:0] r;
    logic [`NUM_TAGS-1:0] rdy;
    rdy = '1;
    if (ready_mode[row] == ready_rand) begin
      r = next_rand();
      for (int k = 0; k < `NUM_TAGS; k++) begin
        rdy[k] = (r[2*k +: 2] != 2'b00);
      end
    end else if (ready_mode[row] == ready_hold0 && t < hold_len[row]) begin
      rdy[0] = 1'b0;
    end
    return rdy;
  endfunction

  task automatic check_output(input int k);
    int expected;
    if (lane_off[k]) begin
      if (corr_valid[k]) begin
        $display("disabled lane %0d raised corr_valid at %0t", k, $time);
        err_cnt++;
      end
      if (corr_data[k] != '0) begin
        $display("mismatch at %0t: disabled lane %0d drove %0d, expected 0",
                 $time, k, int'(corr_data[k]));
        err_cnt++;
      end
    end else if (corr_valid[k] && corr_ready[k]) begin
      if (exp_q[k].size() == 0) begin
        $display("lane %0d gave a result that no input sample accounts for at %0t", k, $time);
        err_cnt++;
      end else begin
        expected = exp_q[k].pop_front();
        check_cnt++;
        if (int'(corr_data[k]) != expected) begin
          $display("mismatch at %0t: lane %0d got %0d, expected %0d",
                   $time, k, int'(corr_data[k]), expected);
          err_cnt++;
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // model and output checks at mid cycle
  ////////////////////////////////////////

  always @(negedge clk) begin
    in_fire = in_valid && in_ready;
    if (rst_n) begin
      if (!in_ready) begin
        saw_full = 1'b1;
      end
      if (in_fire) begin
        win_q.push_front(int'(in_data));
        if (win_q.size() > `TAG_LEN) begin
          win_q.delete(`TAG_LEN);
        end
        if (win_q.size() == `TAG_LEN) begin
          for (int k = 0; k < `NUM_TAGS; k++) begin
            if (!lane_off[k]) begin
              exp_q[k].push_back(window_corr(k));
            end
          end
        end
      end
      for (int k = 0; k < `NUM_TAGS; k++) begin
        check_output(k);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  task automatic run_test(input int row);
    int accepted;
    int t;
    int err_start;
    int check_start;
    logic [31:0] r;
    accepted = 0;
    t = 0;
    err_start = err_cnt;
    check_start = check_cnt;
    saw_full = 1'b0;
    while (accepted < test_len[row]) begin
      @(posedge clk);
      if (in_fire) begin
        accepted++;
      end
      if (accepted >= test_len[row]) begin
        in_valid <= 1'b0;
      end else if (!in_valid || in_fire) begin
        r = next_rand();
        in_valid <= int'(r % 100) < valid_pct[row];
        in_data <= r[15:8];
      end
      corr_ready <= ready_pattern(row, t);
      t++;
    end
    // drain what is still in the FIFO and the lanes
    while (pending() > 0) begin
      @(posedge clk);
      corr_ready <= ready_pattern(row, t);
      t++;
    end
    if (ready_mode[row] == ready_hold0 && !saw_full) begin
      $display("in_ready never dropped while lane 0 was held in test %s", test_name[row]);
      err_cnt++;
    end
    $display("test %s: %0d samples, %0d results checked, %0d errors", test_name[row],
             test_len[row], check_cnt - check_start, err_cnt - err_start);
  endtask

  initial begin
    int total;
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_data = '0;
    corr_ready = '0;
    in_fire = 1'b0;
    saw_full = 1'b0;
    check_cnt = 0;
    err_cnt = 0;
    total = 0;
    for (int i = 0; i < num_tests; i++) begin
      total = total + test_len[i];
    end
    cycle_limit = 20 * total;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (!in_ready || corr_valid != '0) begin
      $display("after reset in_ready was low or a corr_valid was high");
      err_cnt++;
    end
    for (int i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    // catch any late or duplicated result
    repeat (10) @(posedge clk);
    $display("tests: %0d, results checked: %0d, errors: %0d", num_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== xcorr_lane/xcorr_lane.sv ====
////////////////////////////////////////
// correlator lane
// sliding window against one +/-1 tag code,
// two pipeline stages with output stall
////////////////////////////////////////

`timescale 1ns/1ps

`include "xcorr_consts.svh"

module xcorr_lane #(
  parameter int lane_id = 0
) (
  input  logic                clk,
  input  logic                rst_n,

  // broadcast sample stream
  input  logic                sample_take,
  input  xcorr_pkg::sample_t  sample_data,
  output logic                lane_ready,

  // result stream
  output logic                corr_valid,
  input  logic                corr_ready,
  output xcorr_pkg::corr_t    corr_data
);

  import xcorr_pkg::*;

  localparam tag_code_t code = tag_code(lane_id);

  localparam int cnt_w = $clog2(`TAG_LEN);
  localparam logic [cnt_w-1:0] last_fill = cnt_w'(`TAG_LEN - 1);

  // older samples; the newest one comes straight from the FIFO head
  sample_t hist [`TAG_LEN-1];
  sample_t window [`TAG_LEN];

  lane_state_t state;
  logic [cnt_w-1:0] fill_cnt;
  logic window_full;

  logic s1_valid;
  corr_t s1_term [`TAG_LEN];
  corr_t sum;

  logic out_en;

  // output stage free or being emptied
  assign out_en = !corr_valid || corr_ready;
  assign lane_ready = out_en;

  // the TAG_LEN-th sample completes the first window
  assign window_full = (state == LANE_RUN) || (fill_cnt == last_fill);

  always_comb begin
    window[0] = sample_data;
    for (int i = 1; i < `TAG_LEN; i++) begin
      window[i] = hist[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (sample_take) begin
      for (int i = 0; i < `TAG_LEN - 1; i++) begin
        hist[i] <= window[i];
      end
    end
  end

  ////////////////////////////////////////
  // fill tracking
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= LANE_FILL;
      fill_cnt <= '0;
    end else if (sample_take && state == LANE_FILL) begin
      fill_cnt <= fill_cnt + 1'b1;
      if (fill_cnt == last_fill) begin
        state <= LANE_RUN;
      end
    end
  end

  ////////////////////////////////////////
  // stage 1 signed terms
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (sample_take) begin
      for (int i = 0; i < `TAG_LEN; i++) begin
        s1_term[i] <= code[i] ? corr_t'(window[i]) : -corr_t'(window[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (out_en) begin
      s1_valid <= sample_take && window_full;
    end
  end

  ////////////////////////////////////////
  // stage 2 sum and output
  ////////////////////////////////////////

  always_comb begin
    sum = '0;
    for (int i = 0; i < `TAG_LEN; i++) begin
      sum = sum + s1_term[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      corr_valid <= 1'b0;
    end else if (out_en) begin
      corr_valid <= s1_valid;
    end
  end

  // held while the consumer stalls
  always_ff @(posedge clk) begin
    if (out_en && s1_valid) begin
      corr_data <= sum;
    end
  end

endmodule
